// ==== source/ntt_pkg.sv ====
package ntt_pkg;

    // ============================================================
    // Widths and modulus
    // ============================================================

    // One residue per word with the top bit zero for values below Q
    localparam int coeff_w = 24;
    localparam logic [coeff_w-1:0] ntt_q = 24'd8380417;

    // Address field width carried in commands and requests
    localparam int req_addr_w = 6;

    // ============================================================
    // Command and request types
    // ============================================================

    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // Host command for one butterfly stage or one pointwise pass
    typedef struct packed {
        mode_t                 mode;
        logic [req_addr_w-1:0] len;
        logic [req_addr_w-1:0] src_base;
        logic [req_addr_w-1:0] dst_base;
        logic                  accumulate;
    } ntt_cmd_t;

    // One operation travelling down the pipeline
    typedef struct packed {
        mode_t                 mode;
        logic                  accumulate;
        logic [req_addr_w-1:0] dst_addr0;
        logic [req_addr_w-1:0] dst_addr1;
        logic                  valid;
    } op_req_t;

    // Butterfly view with u and v from bank A and twiddle w from bank B
    typedef struct packed {
        logic [coeff_w-1:0] u;
        logic [coeff_w-1:0] v;
        logic [coeff_w-1:0] w;
    } bf_operands_t;

    // Pointwise view with a from source, c from destination and b from bank B
    typedef struct packed {
        logic [coeff_w-1:0] a;
        logic [coeff_w-1:0] c;
        logic [coeff_w-1:0] b;
    } pw_operands_t;

    typedef union packed {
        bf_operands_t bf;
        pw_operands_t pw;
    } exec_operands_u;

    // Single bank A write
    typedef struct packed {
        logic                  en;
        logic [req_addr_w-1:0] addr;
        logic [coeff_w-1:0]    data;
    } wr_req_t;

endpackage

// ==== source/coeff_store.sv ====
`timescale 1ns/100ps

module coeff_store #(
    parameter int ADDR_W = 6
) (
    input  logic                       clk,
    // Host load and readback
    input  logic                       host_wr_en,
    input  logic                       host_wr_bank,
    input  logic [ADDR_W-1:0]          host_addr,
    input  logic [ntt_pkg::coeff_w-1:0] host_wr_data,
    // Engine reads
    input  logic [ADDR_W-1:0]          rd_addr0,
    input  logic [ADDR_W-1:0]          rd_addr1,
    input  logic [ADDR_W-1:0]          rd_addr_b,
    // Engine writes to bank A
    input  ntt_pkg::wr_req_t           wr0,
    input  ntt_pkg::wr_req_t           wr1,
    output logic [ntt_pkg::coeff_w-1:0] rd_data0,
    output logic [ntt_pkg::coeff_w-1:0] rd_data1,
    output logic [ntt_pkg::coeff_w-1:0] rd_data_b,
    output logic [ntt_pkg::coeff_w-1:0] host_rd_data
);
    import ntt_pkg::*;

    localparam int depth = 2 ** ADDR_W;

    // Bank A holds the working polynomial, bank B operands and twiddles
    logic [coeff_w-1:0] bank_a [depth];
    logic [coeff_w-1:0] bank_b [depth];

    logic [ADDR_W-1:0] wr_addr0;
    logic [ADDR_W-1:0] wr_addr1;

    assign wr_addr0 = ADDR_W'(wr0.addr);
    assign wr_addr1 = ADDR_W'(wr1.addr);

    // ============================================================
    // Bank A with the host write ahead of the engine writes
    // ============================================================

    // Later assignments take priority, so engine writes win
    always_ff @(posedge clk) begin
        if (host_wr_en && !host_wr_bank) begin
            bank_a[host_addr] <= host_wr_data;
        end
        if (wr0.en) begin
            bank_a[wr_addr0] <= wr0.data;
        end
        // Butterfly partner never shares an address with wr0
        if (wr1.en) begin
            bank_a[wr_addr1] <= wr1.data;
        end
    end

    // Bank B is only written by the host
    always_ff @(posedge clk) begin
        if (host_wr_en && host_wr_bank) begin
            bank_b[host_addr] <= host_wr_data;
        end
    end

    // ============================================================
    // Registered reads
    // ============================================================

    always_ff @(posedge clk) begin
        rd_data0     <= bank_a[rd_addr0];
        rd_data1     <= bank_a[rd_addr1];
        rd_data_b    <= bank_b[rd_addr_b];
        // Readback port returns old data on a same-cycle write
        host_rd_data <= bank_a[host_addr];
    end

endmodule

// ==== source/op_decode.sv ====
`timescale 1ns/100ps

module op_decode #(
    parameter int ADDR_W  = 6,
    parameter int COEFF_N = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  ntt_pkg::ntt_cmd_t cmd,
    input  logic              cmd_valid,
    input  logic              done,
    output logic              cmd_ready,
    output logic [ADDR_W-1:0] rd_addr0,
    output logic [ADDR_W-1:0] rd_addr1,
    output logic [ADDR_W-1:0] rd_addr_b,
    output ntt_pkg::op_req_t  op
);
    import ntt_pkg::*;

    localparam int cnt_w = $clog2(COEFF_N);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain
    } state_t;

    state_t            state;
    ntt_cmd_t          cmd_q;
    logic [cnt_w-1:0]  op_cnt;
    logic [cnt_w-1:0]  last_cnt;
    logic              is_bf;
    logic              cmd_take;

    // Address arithmetic terms
    logic [ADDR_W-1:0] k_w;
    logic [ADDR_W-1:0] len_w;
    logic [ADDR_W-1:0] len_mask;
    logic [ADDR_W-1:0] bf_off;
    logic [ADDR_W-1:0] src_w;
    logic [ADDR_W-1:0] dst_w;

    // ============================================================
    // Command handshake and sequencing
    // ============================================================

    // Ready while idle, and again in the done cycle of the previous command
    assign cmd_ready = (state == st_idle) || ((state == st_drain) && done);
    assign cmd_take  = cmd_valid && cmd_ready;

    assign is_bf    = (cmd_q.mode == ct) || (cmd_q.mode == gs);
    // Half the length for butterflies, full length for pointwise
    assign last_cnt = is_bf ? cnt_w'(COEFF_N / 2 - 1) : cnt_w'(COEFF_N - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            op_cnt <= '0;
        end else begin
            case (state)
                st_issue: begin
                    op_cnt <= op_cnt + 1'b1;
                    if (op_cnt == last_cnt) begin
                        state <= st_drain;
                    end
                end
                default: begin
                    if (cmd_take) begin
                        state  <= st_issue;
                        op_cnt <= '0;
                    end else if (done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Command fields held for the whole pass
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            cmd_q <= cmd;
        end
    end

    // ============================================================
    // Address generation
    // ============================================================

    assign k_w      = ADDR_W'(op_cnt);
    assign len_w    = ADDR_W'(cmd_q.len);
    assign len_mask = len_w - 1'b1;
    assign src_w    = ADDR_W'(cmd_q.src_base);
    assign dst_w    = ADDR_W'(cmd_q.dst_base);

    // j = (k div len)*2*len + (k mod len), len a power of two
    assign bf_off = k_w + (k_w & ~len_mask);

    always_comb begin
        if (is_bf) begin
            rd_addr0 = src_w + bf_off;
            rd_addr1 = src_w + bf_off + len_w;
        end else begin
            // a from source, c from destination for accumulate
            rd_addr0 = src_w + k_w;
            rd_addr1 = dst_w + k_w;
        end
        // Twiddle index k, or operand b index i
        rd_addr_b = k_w;
    end

    // Request that follows the reads down the pipeline
    always_comb begin
        op.mode       = cmd_q.mode;
        op.accumulate = cmd_q.accumulate;
        op.dst_addr0  = is_bf ? req_addr_w'(rd_addr0) : req_addr_w'(rd_addr1);
        op.dst_addr1  = req_addr_w'(rd_addr1);
        op.valid      = (state == st_issue);
    end

endmodule

// ==== source/butterfly_exec.sv ====
`timescale 1ns/100ps

module butterfly_exec (
    input  logic                        clk,
    input  logic                        rst,
    input  ntt_pkg::op_req_t            op_in,
    input  logic [ntt_pkg::coeff_w-1:0] rd_data0,
    input  logic [ntt_pkg::coeff_w-1:0] rd_data1,
    input  logic [ntt_pkg::coeff_w-1:0] rd_data_b,
    output ntt_pkg::op_req_t            op_out,
    output logic [ntt_pkg::coeff_w-1:0] res0,
    output logic [ntt_pkg::coeff_w-1:0] res1
);
    import ntt_pkg::*;

    // Both inputs below Q
    function automatic logic [coeff_w-1:0] add_mod(
        input logic [coeff_w-1:0] x,
        input logic [coeff_w-1:0] y
    );
        logic [coeff_w:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        if (sum >= {1'b0, ntt_q}) begin
            sum = sum - {1'b0, ntt_q};
        end
        return sum[coeff_w-1:0];
    endfunction

    // Wraps through 2^24 when x < y and still lands below Q
    function automatic logic [coeff_w-1:0] sub_mod(
        input logic [coeff_w-1:0] x,
        input logic [coeff_w-1:0] y
    );
        if (x >= y) begin
            return x - y;
        end
        return x - y + ntt_q;
    endfunction

    op_req_t              op_rd;
    op_req_t              op_s1;
    exec_operands_u       ops;
    logic [2*coeff_w-1:0] prod_d;
    logic [2*coeff_w-1:0] prod_q;
    logic [coeff_w-1:0]   keep_d;
    logic [coeff_w-1:0]   keep_q;
    logic [coeff_w-1:0]   red;
    logic [coeff_w-1:0]   res0_d;
    logic [coeff_w-1:0]   res1_d;

    // ============================================================
    // Stage 0 aligns the request with the read data
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            op_rd <= '0;
            op_s1 <= '0;
            op_out <= '0;
        end else begin
            op_rd  <= op_in;
            op_s1  <= op_rd;
            op_out <= op_s1;
        end
    end

    // ============================================================
    // Stage 1 forms the product and the term carried alongside it
    // ============================================================

    always_comb begin
        ops.bf.u = rd_data0;
        ops.bf.v = rd_data1;
        ops.bf.w = rd_data_b;
        prod_d   = '0;
        keep_d   = '0;
        case (op_rd.mode)
            ct: begin
                prod_d = ops.bf.w * ops.bf.v;
                keep_d = ops.bf.u;
            end
            gs: begin
                // Difference is scaled while the sum passes straight through
                prod_d = sub_mod(ops.bf.u, ops.bf.v) * ops.bf.w;
                keep_d = add_mod(ops.bf.u, ops.bf.v);
            end
            pwm: begin
                prod_d = ops.pw.a * ops.pw.b;
                keep_d = op_rd.accumulate ? ops.pw.c : '0;
            end
            pwa:     keep_d = add_mod(ops.pw.a, ops.pw.b);
            pws:     keep_d = sub_mod(ops.pw.a, ops.pw.b);
            default: keep_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        prod_q <= prod_d;
        keep_q <= keep_d;
    end

    // ============================================================
    // Stage 2 reduces and applies the final combine
    // ============================================================

    assign red = coeff_w'(prod_q % ntt_q);

    always_comb begin
        case (op_s1.mode)
            ct: begin
                res0_d = add_mod(keep_q, red);
                res1_d = sub_mod(keep_q, red);
            end
            gs: begin
                res0_d = keep_q;
                res1_d = red;
            end
            // Accumulate term is zero when not requested
            pwm: begin
                res0_d = add_mod(red, keep_q);
                res1_d = red;
            end
            default: begin
                res0_d = keep_q;
                res1_d = keep_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        res0 <= res0_d;
        res1 <= res1_d;
    end

endmodule

// ==== source/result_writeback.sv ====
`timescale 1ns/100ps

module result_writeback #(
    parameter int COEFF_N = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  ntt_pkg::op_req_t            op_in,
    input  logic [ntt_pkg::coeff_w-1:0] res0,
    input  logic [ntt_pkg::coeff_w-1:0] res1,
    output ntt_pkg::wr_req_t            wr0,
    output ntt_pkg::wr_req_t            wr1,
    output logic                        done
);
    import ntt_pkg::*;

    localparam int cnt_w = $clog2(COEFF_N);

    logic             is_bf;
    logic [cnt_w-1:0] wr_cnt;
    logic [cnt_w-1:0] last_cnt;

    assign is_bf = (op_in.mode == ct) || (op_in.mode == gs);

    // ============================================================
    // Write request mapping
    // ============================================================

    // Butterflies update both halves in place, pointwise only wr0
    always_comb begin
        wr0.en   = op_in.valid;
        wr0.addr = op_in.dst_addr0;
        wr0.data = res0;
        wr1.en   = op_in.valid && is_bf;
        wr1.addr = op_in.dst_addr1;
        wr1.data = res1;
    end

    // ============================================================
    // Completion count
    // ============================================================

    assign last_cnt = is_bf ? cnt_w'(COEFF_N / 2 - 1) : cnt_w'(COEFF_N - 1);

    // done lands in the cycle after the last write is committed
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (op_in.valid) begin
                if (wr_cnt == last_cnt) begin
                    wr_cnt <= '0;
                    done   <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/ntt_wrapper.sv ====
`timescale 1ns/100ps

module ntt_wrapper #(
    parameter int ADDR_W  = 6,
    parameter int COEFF_N = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    // Command input
    input  ntt_pkg::ntt_cmd_t           cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    // Host load and readback
    input  logic                        host_wr_en,
    input  logic                        host_wr_bank,
    input  logic [ADDR_W-1:0]           host_addr,
    input  logic [ntt_pkg::coeff_w-1:0] host_wr_data,
    output logic [ntt_pkg::coeff_w-1:0] host_rd_data,
    output logic                        done
);
    import ntt_pkg::*;

    // Read side
    logic [ADDR_W-1:0]  rd_addr0;
    logic [ADDR_W-1:0]  rd_addr1;
    logic [ADDR_W-1:0]  rd_addr_b;
    logic [coeff_w-1:0] rd_data0;
    logic [coeff_w-1:0] rd_data1;
    logic [coeff_w-1:0] rd_data_b;

    // Pipeline and write side
    op_req_t            op_dec;
    op_req_t            op_exe;
    logic [coeff_w-1:0] res0;
    logic [coeff_w-1:0] res1;
    wr_req_t            wr0;
    wr_req_t            wr1;

    coeff_store #(
        .ADDR_W(ADDR_W)
    ) i_coeff_store (
        .clk          (clk),
        .host_wr_en   (host_wr_en),
        .host_wr_bank (host_wr_bank),
        .host_addr    (host_addr),
        .host_wr_data (host_wr_data),
        .rd_addr0     (rd_addr0),
        .rd_addr1     (rd_addr1),
        .rd_addr_b    (rd_addr_b),
        .wr0          (wr0),
        .wr1          (wr1),
        .rd_data0     (rd_data0),
        .rd_data1     (rd_data1),
        .rd_data_b    (rd_data_b),
        .host_rd_data (host_rd_data)
    );

    op_decode #(
        .ADDR_W (ADDR_W),
        .COEFF_N(COEFF_N)
    ) i_op_decode (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .done     (done),
        .cmd_ready(cmd_ready),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_addr_b(rd_addr_b),
        .op       (op_dec)
    );

    butterfly_exec i_butterfly_exec (
        .clk      (clk),
        .rst      (rst),
        .op_in    (op_dec),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .rd_data_b(rd_data_b),
        .op_out   (op_exe),
        .res0     (res0),
        .res1     (res1)
    );

    result_writeback #(
        .COEFF_N(COEFF_N)
    ) i_result_writeback (
        .clk  (clk),
        .rst  (rst),
        .op_in(op_exe),
        .res0 (res0),
        .res1 (res1),
        .wr0  (wr0),
        .wr1  (wr1),
        .done (done)
    );

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // Free running clock, 40 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held over the first few rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/ntt_wrapper_tb.sv ====
`timescale 1ns/100ps

module ntt_wrapper_tb;
    import ntt_pkg::*;

    localparam int ADDR_W   = 6;
    localparam int COEFF_N  = 16;
    localparam int max_recs = 256;

    logic               clk;
    logic               rst;
    ntt_cmd_t           cmd;
    logic               cmd_valid;
    logic               cmd_ready;
    logic               host_wr_en;
    logic               host_wr_bank;
    logic [ADDR_W-1:0]  host_addr;
    logic [coeff_w-1:0] host_wr_data;
    logic [coeff_w-1:0] host_rd_data;
    logic               done;

    // Parsed records from the test file
    string rec_kind [max_recs];
    string rec_name [max_recs];
    int    rec_f    [max_recs][10];
    int    n_recs;
    int    n_tests;

    // Run bookkeeping
    int cycle_cnt;
    int cycle_limit;
    int done_seen;
    int cmd_count;
    int errors;
    int checks;
    int tests_failed;

    clock_gen i_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    ntt_wrapper #(
        .ADDR_W (ADDR_W),
        .COEFF_N(COEFF_N)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .host_wr_en  (host_wr_en),
        .host_wr_bank(host_wr_bank),
        .host_addr   (host_addr),
        .host_wr_data(host_wr_data),
        .host_rd_data(host_rd_data),
        .done        (done)
    );

    // ============================================================
    // Timeout and done pulse monitor
    // ============================================================

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst && done) begin
            done_seen <= done_seen + 1;
        end
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ============================================================
    // Test file parsing
    // ============================================================

    function automatic int mode_code(input string name);
        if (name == "ct") return int'(ct);
        if (name == "gs") return int'(gs);
        if (name == "pwm") return int'(pwm);
        if (name == "pwa") return int'(pwa);
        if (name == "pws") return int'(pws);
        $display("Unknown mode name %s in the test file", name);
        errors++;
        return -1;
    endfunction

    task automatic read_test_file();
        int                 fd;
        int                 cnt;
        logic [8*128-1:0]   line;
        logic [8*24-1:0]    kind_buf;
        logic [8*24-1:0]    name_buf;
        logic [8*8-1:0]     mode_a;
        logic [8*8-1:0]     mode_b;
        int                 v [8];
        string              kind;
        fd = $fopen("verification/ntt_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file verification/ntt_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_recs < max_recs) begin
            line = '0;
            if ($fgets(line, fd) == 0) continue;
            cnt = $sscanf(line, "%s", kind_buf);
            if (cnt < 1) continue;
            kind = string'(kind_buf);
            // Comment lines
            if (kind == "#") continue;
            rec_kind[n_recs] = kind;
            for (int i = 0; i < 10; i++) rec_f[n_recs][i] = 0;
            if (kind == "test") begin
                cnt = $sscanf(line, "%s %s", kind_buf, name_buf);
                rec_name[n_recs] = string'(name_buf);
                n_tests++;
            end else if (kind == "loada" || kind == "loadb" || kind == "expect") begin
                cnt = $sscanf(line, "%s %d %d", kind_buf, v[0], v[1]);
                rec_f[n_recs][0] = v[0];
                rec_f[n_recs][1] = v[1];
            end else if (kind == "cmd" || kind == "pair") begin
                cnt = $sscanf(line, "%s %s %d %d %d %d %s %d %d %d %d", kind_buf,
                              mode_a, v[0], v[1], v[2], v[3], mode_b, v[4], v[5], v[6], v[7]);
                rec_f[n_recs][0] = mode_code(string'(mode_a));
                for (int i = 0; i < 4; i++) rec_f[n_recs][i+1] = v[i];
                if (kind == "pair") begin
                    rec_f[n_recs][5] = mode_code(string'(mode_b));
                    for (int i = 0; i < 4; i++) rec_f[n_recs][i+6] = v[i+4];
                end
            end
            n_recs++;
        end
        $fclose(fd);
    endtask

    // ============================================================
    // Host port and command tasks
    // ============================================================

    task automatic load_word(input logic bank, input int addr, input int data);
        @(negedge clk);
        host_wr_en   = 1'b1;
        host_wr_bank = bank;
        host_addr    = ADDR_W'(addr);
        host_wr_data = coeff_w'(data);
        @(negedge clk);
        host_wr_en   = 1'b0;
    endtask

    // Readback data is registered, so it is taken one edge later
    task automatic read_word(input int addr, output int data);
        @(negedge clk);
        host_addr = ADDR_W'(addr);
        @(negedge clk);
        data = int'(host_rd_data);
    endtask

    function automatic ntt_cmd_t build_cmd(input int r, input int base);
        ntt_cmd_t c;
        c.mode       = mode_t'(rec_f[r][base]);
        c.len        = req_addr_w'(rec_f[r][base+1]);
        c.src_base   = req_addr_w'(rec_f[r][base+2]);
        c.dst_base   = req_addr_w'(rec_f[r][base+3]);
        c.accumulate = rec_f[r][base+4] != 0;
        return c;
    endfunction

    // Returns on the falling edge before the rising edge that takes the command
    task automatic wait_ready();
        while (!cmd_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_done();
        forever begin
            @(negedge clk);
            if (done) break;
        end
    endtask

    task automatic run_command(input int r);
        @(negedge clk);
        cmd       = build_cmd(r, 0);
        cmd_valid = 1'b1;
        wait_ready();
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_done();
        cmd_count++;
    endtask

    // Second command held valid while the first one is still running
    task automatic run_pair(input int r, input string name, inout int test_err);
        @(negedge clk);
        cmd       = build_cmd(r, 0);
        cmd_valid = 1'b1;
        wait_ready();
        @(negedge clk);
        cmd = build_cmd(r, 5);
        wait_ready();
        checks++;
        assert (done) else begin
            $display("Test %s, cmd_ready rose without the done pulse of the first command",
                     name);
            errors++;
            test_err++;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_done();
        cmd_count += 2;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        int    got;
        int    test_err;
        int    idle;
        string name;
        cmd          = '0;
        cmd_valid    = 1'b0;
        host_wr_en   = 1'b0;
        host_wr_bank = 1'b0;
        host_addr    = '0;
        host_wr_data = '0;
        cycle_cnt    <= 0;
        cycle_limit  = 32'h7fff_ffff;
        done_seen    <= 0;
        cmd_count    = 0;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        n_recs       = 0;
        n_tests      = 0;
        test_err     = 0;
        name         = "none";
        void'($urandom(11482));

        read_test_file();
        // Budget per test from the test count
        cycle_limit = n_tests * (COEFF_N + 50) + 200;

        @(negedge clk);
        while (rst) @(negedge clk);
        checks++;
        assert (cmd_ready && !done) else begin
            $display("After reset cmd_ready is not high or done is not low");
            errors++;
        end

        for (int r = 0; r < n_recs; r++) begin
            case (rec_kind[r])
                "test": begin
                    name     = rec_name[r];
                    test_err = 0;
                end
                "loada": load_word(1'b0, rec_f[r][0], rec_f[r][1]);
                "loadb": load_word(1'b1, rec_f[r][0], rec_f[r][1]);
                "cmd":   run_command(r);
                "pair":  run_pair(r, name, test_err);
                "expect": begin
                    read_word(rec_f[r][0], got);
                    checks++;
                    assert (got == rec_f[r][1]) else begin
                        $display("MISMATCH test %s addr %0d expected %0d actual %0d",
                                 name, rec_f[r][0], rec_f[r][1], got);
                        errors++;
                        test_err++;
                    end
                end
                "end": begin
                    // Let any stray done pulse show up before counting
                    repeat (4) @(negedge clk);
                    checks++;
                    assert (done_seen == cmd_count) else begin
                        $display("Test %s, saw %0d done pulses for %0d commands",
                                 name, done_seen, cmd_count);
                        errors++;
                        test_err++;
                    end
                    if (test_err != 0) tests_failed++;
                    $display("Test %s %s", name, (test_err == 0) ? "ok" : "failed");
                    idle = $urandom % 4;
                    repeat (idle) @(negedge clk);
                end
                default: begin
                    $display("Unknown record kind %s in the test file", rec_kind[r]);
                    errors++;
                end
            endcase
        end

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, tests_failed, checks, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/ntt_tests.txt ====
# kind: test name | loada/loadb addr value | expect addr value | end
# cmd mode len src dst acc | pair mode len src dst acc mode len src dst acc
test reset_readback
loada 0 5
loada 1 7
expect 0 5
expect 1 7
end
test ct_len8
loada 0 1
loada 8 2
loadb 0 3
loada 1 8380416
loada 9 1
loadb 1 1
loada 2 1000
loada 10 4000000
loadb 2 3000
cmd ct 8 0 0 0
expect 0 7
expect 8 8380412
expect 1 0
expect 9 8380415
expect 2 7624273
expect 10 758144
end
test ct_len1
loada 4 10
loada 5 20
loadb 2 5
cmd ct 1 0 0 0
expect 4 110
expect 5 8380327
end
test gs_len4
loada 16 50
loada 20 30
loadb 0 7
loada 17 3
loada 21 8
loadb 1 2
cmd gs 4 16 0 0
expect 16 80
expect 20 140
expect 17 11
expect 21 8380407
end
test ct_gs_inverse
loada 32 9
loada 33 4
loadb 0 2
cmd ct 1 32 0 0
loadb 0 4190209
cmd gs 1 32 0 0
expect 32 18
expect 33 8
end
test pwa_pws
loada 0 100
loadb 0 8380400
loada 1 5
loadb 1 3
cmd pwa 0 0 40 0
cmd pws 0 0 48 0
expect 40 83
expect 41 8
expect 48 117
expect 49 2
expect 0 100
end
test pwm_acc
loada 0 4000000
loadb 0 3000
cmd pwm 0 0 48 0
expect 48 7623273
cmd pwm 0 0 48 1
expect 48 6866129
expect 0 4000000
end
test busy_hold
loada 0 20
loadb 0 6
pair pwa 0 0 16 0 pws 0 0 32 0
expect 16 26
expect 32 14
end

// ==== compile.f ====
source/ntt_pkg.sv
source/coeff_store.sv
source/op_decode.sv
source/butterfly_exec.sv
source/result_writeback.sv
source/ntt_wrapper.sv
verification/clock_gen.sv
verification/ntt_wrapper_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ntt_wrapper_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
